// File: build.f
hdl/fetch_pkg.sv
hdl/pc_unit.sv
hdl/instr_mem.sv
hdl/imem_apb_loader.sv
hdl/if_stage.sv
hdl/fetch_top.sv
bench/fetch_chk.sv
bench/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - hdl/fetch_pkg.sv
  - hdl/pc_unit.sv
  - hdl/instr_mem.sv
  - hdl/imem_apb_loader.sv
  - hdl/if_stage.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - bench/fetch_chk.sv
      - bench/fetch_tb.sv

// File: bench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	localparam int depth = 256;
	localparam int drive_delay = 5;

	logic clk;
	logic reset;
	logic stall;
	logic checking;
	logic halted;
	fetch_pkg::apb_req_t apb_req;
	fetch_pkg::apb_rsp_t apb_rsp;
	fetch_pkg::redirect_t redirect;
	fetch_pkg::if_id_t if_id;

	// reference model of memory, pc and run/halt
	fetch_pkg::word_t m_mem [depth];
	fetch_pkg::pc_t m_pc;
	fetch_pkg::pc_t m_load_addr;
	fetch_pkg::fetch_state_t m_state;
	fetch_pkg::if_id_t m_if_id;
	logic m_run;

	fetch_top #(
		.imem_depth(depth)
	) u_fetch_top (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.redirect(redirect),
		.stall(stall),
		.if_id(if_id),
		.halted(halted)
	);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset) begin
			m_run = 1'b0;
			m_load_addr = '0;
			m_state = fetch_pkg::st_idle;
			m_pc = '0;
			m_if_id = '0;
		end else begin
			// if/id moves only while running and not stalled
			if (m_state != fetch_pkg::st_run) begin
				m_if_id = '0;
			end else if (!stall) begin
				if (redirect.pc_src != fetch_pkg::pc_seq) begin
					m_if_id = '0;
				end else begin
					m_if_id.valid = 1'b1;
					m_if_id.pc = m_pc;
					m_if_id.pc_next = m_pc + 32'd1;
					m_if_id.instr = m_mem[m_pc % depth];
				end
			end
			// pc and run/halt, old run bit
			if (!m_run) begin
				m_state = fetch_pkg::st_idle;
				m_pc = '0;
			end else if (m_state == fetch_pkg::st_idle) begin
				m_state = fetch_pkg::st_run;
				m_pc = '0;
			end else if (m_state == fetch_pkg::st_run && !stall) begin
				case (redirect.pc_src)
					fetch_pkg::pc_branch:   m_pc = redirect.branch_target;
					fetch_pkg::pc_jump:     m_pc = redirect.jump_target;
					fetch_pkg::pc_register: m_pc = redirect.reg_target;
					default: begin
						// halt word freezes the pc
						if (m_mem[m_pc % depth] == fetch_pkg::halt_word) begin
							m_state = fetch_pkg::st_halted;
						end else begin
							m_pc = m_pc + 32'd1;
						end
					end
				endcase
			end
			// debug port writes land on the access edge
			if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
				case (apb_req.paddr)
					fetch_pkg::reg_ctrl: m_run = apb_req.pwdata[0];
					fetch_pkg::reg_addr: m_load_addr = apb_req.pwdata;
					fetch_pkg::reg_data: begin
						// dropped while running
						if (!m_run) begin
							m_mem[m_load_addr % depth] = apb_req.pwdata;
							m_load_addr = m_load_addr + 32'd1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic stop_on_error();
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_if_id(input string name, input fetch_pkg::if_id_t act,
			input fetch_pkg::if_id_t exp);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_word(input string name, input fetch_pkg::word_t act,
			input fetch_pkg::word_t exp);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
			stop_on_error();
		end
	endtask

	// every cycle, registered outputs settled
	always begin
		@(posedge clk);
		#1;
		if (checking) begin
			check_if_id("if_id", if_id, m_if_id);
			check_bit("halted", halted, m_state == fetch_pkg::st_halted);
			if (u_fetch_top.u_if_stage.u_fetch_chk.fail_count != 0) begin
				$display("an assertion in fetch_chk failed");
				stop_on_error();
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////

	function automatic fetch_pkg::pc_t pick_target();
		// stays inside the loaded words
		return fetch_pkg::pc_t'($urandom_range(0, 47));
	endfunction

	task automatic drive_fetch(input logic hold, input fetch_pkg::pc_src_t src);
		@(posedge clk);
		#drive_delay;
		stall = hold;
		redirect.pc_src = src;
		redirect.branch_target = pick_target();
		redirect.jump_target = pick_target();
		redirect.reg_target = pick_target();
	endtask

	// setup then access, zero wait states expected
	task automatic apb_xfer(input logic write, input fetch_pkg::apb_addr_t addr,
			input fetch_pkg::word_t wdata, output fetch_pkg::word_t rdata, output logic err);
		@(posedge clk);
		#drive_delay;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(posedge clk);
		#drive_delay;
		apb_req.penable = 1'b1;
		#1;
		// slave never inserts wait states
		check_bit("pready", apb_rsp.pready, 1'b1);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// transfer completes on this edge
		@(posedge clk);
		#drive_delay;
		apb_req = '0;
	endtask

	task automatic reg_write(input fetch_pkg::apb_addr_t addr, input fetch_pkg::word_t data,
			input logic exp_err);
		fetch_pkg::word_t rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_bit("pslverr", err, exp_err);
	endtask

	task automatic reg_read(input fetch_pkg::apb_addr_t addr, input fetch_pkg::word_t exp);
		fetch_pkg::word_t rd;
		logic err;
		apb_xfer(1'b0, addr, '0, rd, err);
		check_bit("pslverr", err, 1'b0);
		check_word("prdata", rd, exp);
	endtask

	// random words, never the halt word
	task automatic load_program(input int count);
		fetch_pkg::word_t w;
		reg_write(fetch_pkg::reg_addr, 32'd0, 1'b0);
		for (int i = 0; i < count; i++) begin
			do begin
				w = $urandom();
			end while (w == fetch_pkg::halt_word);
			reg_write(fetch_pkg::reg_data, w, 1'b0);
		end
	endtask

	// word 0 two clocks after the run write edge
	task automatic wait_first_valid();
		int clocks;
		clocks = 0;
		do begin
			@(posedge clk);
			#1;
			clocks++;
		end while (!if_id.valid && clocks < 20);
		if (!if_id.valid) begin
			$display("timeout waiting for the first valid fetch");
			stop_on_error();
		end
		if (clocks != 2) begin
			$display("first valid fetch came %0d clocks after the run write, not 2", clocks);
			stop_on_error();
		end
		check_word("if_id.pc", if_id.pc, 32'd0);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int clocks;
		logic hold;
		fetch_pkg::pc_src_t src;
		fetch_pkg::pc_t halt_pc;
		fetch_pkg::if_id_t exp;

		void'($urandom(62));
		reset = 1'b1;
		stall = 1'b0;
		checking = 1'b0;
		apb_req = '0;
		redirect = '0;
		repeat (16) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		checking = 1'b1;

		// load, auto-increment, bad offset
		load_program(64);
		reg_read(fetch_pkg::reg_addr, 32'd64);
		reg_write(8'h20, 32'd0, 1'b1);

		// straight-line fetch
		reg_write(fetch_pkg::reg_ctrl, 32'd1, 1'b0);
		wait_first_valid();
		repeat (16) drive_fetch(1'b0, fetch_pkg::pc_seq);

		// random stall, reg_pc read while held
		for (int i = 0; i < 32; i++) begin
			hold = (i % 8 == 7) || ($urandom_range(0, 3) == 0);
			drive_fetch(hold, fetch_pkg::pc_seq);
			if (i % 8 == 7) begin
				reg_read(fetch_pkg::reg_pc, m_pc);
			end
		end

		// random redirects, pulled back before the loaded range ends
		for (int i = 0; i < 48; i++) begin
			hold = ($urandom_range(0, 3) == 0);
			src = fetch_pkg::pc_seq;
			if ($urandom_range(0, 99) < 30 || m_pc > 48) begin
				src = fetch_pkg::pc_src_t'($urandom_range(1, 3));
			end
			if (m_pc > 48) begin
				hold = 1'b0;
			end
			drive_fetch(hold, src);
		end
		drive_fetch(1'b0, fetch_pkg::pc_seq);

		// halt word at a random address
		reg_write(fetch_pkg::reg_ctrl, 32'd0, 1'b0);
		halt_pc = fetch_pkg::pc_t'($urandom_range(20, 40));
		reg_write(fetch_pkg::reg_addr, halt_pc, 1'b0);
		reg_write(fetch_pkg::reg_data, fetch_pkg::halt_word, 1'b0);
		reg_write(fetch_pkg::reg_ctrl, 32'd1, 1'b0);
		clocks = 0;
		do begin
			@(posedge clk);
			#1;
			clocks++;
		end while (!halted && clocks < 100);
		if (!halted) begin
			$display("timeout waiting for fetch to halt");
			stop_on_error();
		end
		// halt word goes out with the halt
		exp = '0;
		exp.valid = 1'b1;
		exp.pc = halt_pc;
		exp.pc_next = halt_pc + 32'd1;
		exp.instr = fetch_pkg::halt_word;
		check_if_id("if_id", if_id, exp);
		reg_read(fetch_pkg::reg_pc, halt_pc);
		reg_read(fetch_pkg::reg_status, 32'h1);
		repeat (4) drive_fetch(1'b0, fetch_pkg::pc_seq);
		reg_read(fetch_pkg::reg_pc, halt_pc);

		// stop, reload, restart at 0
		reg_write(fetch_pkg::reg_ctrl, 32'd0, 1'b0);
		drive_fetch(1'b0, fetch_pkg::pc_seq);
		check_bit("halted", halted, 1'b0);
		load_program(64);
		reg_write(fetch_pkg::reg_addr, 32'd10, 1'b0);
		reg_write(fetch_pkg::reg_ctrl, 32'd1, 1'b0);
		wait_first_valid();
		// refused while running, word 10 checked when fetched
		reg_write(fetch_pkg::reg_data, 32'h5a5a_0f0f, 1'b1);
		// running bit only
		reg_read(fetch_pkg::reg_status, 32'h2);
		repeat (24) drive_fetch(1'b0, fetch_pkg::pc_seq);
		reg_write(fetch_pkg::reg_ctrl, 32'd0, 1'b0);
		repeat (4) drive_fetch(1'b0, fetch_pkg::pc_seq);

		if (u_fetch_top.u_if_stage.u_fetch_chk.fail_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("an assertion in fetch_chk failed");
			stop_on_error();
		end
	end

endmodule

`default_nettype wire

// File: bench/fetch_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_chk (
	input wire clk,
	input wire reset,
	input wire logic run,
	input wire logic stall,
	input wire fetch_pkg::redirect_t redirect,
	input wire fetch_pkg::if_id_t if_id,
	input wire fetch_pkg::fetch_state_t state
);

	// bumped by each failing assertion
	int fail_count = 0;

	logic running;
	logic redirect_taken;

	assign running = (state == fetch_pkg::st_run);
	// stall masks the redirect
	assign redirect_taken = running && !stall && (redirect.pc_src != fetch_pkg::pc_seq);

	////////////////////////////////////////////////////////////
	// if/id rules
	////////////////////////////////////////////////////////////

	a_bubble: assert property (@(posedge clk) disable iff (reset)
		redirect_taken |=> !if_id.valid)
		else begin
			$error("if_id valid in the cycle after a redirect");
			fail_count++;
		end

	a_stall_hold: assert property (@(posedge clk) disable iff (reset)
		(running && stall) |=> $stable(if_id))
		else begin
			$error("if_id moved under stall");
			fail_count++;
		end

	// only run falling leaves halted
	a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
		(state == fetch_pkg::st_halted && run) |=> (state == fetch_pkg::st_halted))
		else begin
			$error("halted dropped while run was still set");
			fail_count++;
		end

endmodule

bind if_stage fetch_chk u_fetch_chk (
	.clk(clk),
	.reset(reset),
	.run(run),
	.stall(stall),
	.redirect(redirect),
	.if_id(if_id),
	.state(state)
);

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter int imem_depth = 256
) (
	input wire clk,
	input wire reset,
	// debug/load port
	input wire fetch_pkg::apb_req_t apb_req,
	output fetch_pkg::apb_rsp_t apb_rsp,
	// from decode/control
	input wire fetch_pkg::redirect_t redirect,
	input wire logic stall,
	// to decode
	output fetch_pkg::if_id_t if_id,
	output wire halted
);

	fetch_pkg::imem_wr_t imem_wr;
	fetch_pkg::fetch_state_t state;
	fetch_pkg::pc_t pc;
	logic run;

	////////////////////////////////////////////////////////////
	// debug port
	////////////////////////////////////////////////////////////

	imem_apb_loader u_imem_apb_loader (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.state(state),
		.pc(pc),
		.run(run),
		.imem_wr(imem_wr)
	);

	////////////////////////////////////////////////////////////
	// fetch stage
	////////////////////////////////////////////////////////////

	if_stage #(
		.imem_depth(imem_depth)
	) u_if_stage (
		.clk(clk),
		.reset(reset),
		.run(run),
		.stall(stall),
		.redirect(redirect),
		.imem_wr(imem_wr),
		.if_id(if_id),
		.state(state),
		.pc(pc)
	);

	// state decode only
	assign halted = (state == fetch_pkg::st_halted);

endmodule

`default_nettype wire

// File: hdl/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
	parameter int imem_depth = 256
) (
	input wire clk,
	input wire reset,
	input wire logic run,
	// hold from decode/control
	input wire logic stall,
	input wire fetch_pkg::redirect_t redirect,
	input wire fetch_pkg::imem_wr_t imem_wr,
	output fetch_pkg::if_id_t if_id,
	output fetch_pkg::fetch_state_t state,
	output fetch_pkg::pc_t pc
);

	fetch_pkg::pc_t pc_fetch;
	fetch_pkg::pc_t pc_seq_next;
	fetch_pkg::word_t instr;
	logic is_halt;
	logic flush;

	////////////////////////////////////////////////////////////
	// pc and memory
	////////////////////////////////////////////////////////////

	pc_unit u_pc_unit (
		.clk(clk),
		.reset(reset),
		.run(run),
		.stall(stall),
		.redirect(redirect),
		.halt_seen(is_halt),
		.pc(pc),
		.pc_fetch(pc_fetch),
		.state(state)
	);

	// reads at next pc so instr matches pc this cycle
	instr_mem #(
		.imem_depth(imem_depth)
	) u_instr_mem (
		.clk(clk),
		.rd_addr(pc_fetch),
		.rd_data(instr),
		.is_halt(is_halt),
		.wr(imem_wr)
	);

	////////////////////////////////////////////////////////////
	// if/id register
	////////////////////////////////////////////////////////////

	assign pc_seq_next = pc + 32'd1;
	// any non-seq source drops the word in flight
	assign flush = (redirect.pc_src != fetch_pkg::pc_seq);

	always_ff @(posedge clk) begin
		if (reset) begin
			if_id <= '0;
		end else if (state != fetch_pkg::st_run) begin
			// idle or halted, nothing valid
			if_id <= '0;
		end else if (!stall) begin
			if (flush) begin
				// bubble
				if_id <= '0;
			end else begin
				if_id.valid <= 1'b1;
				if_id.pc <= pc;
				if_id.pc_next <= pc_seq_next;
				// halt word itself goes out once
				if_id.instr <= instr;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/imem_apb_loader.sv
`timescale 1ns/1ps
`default_nettype none

module imem_apb_loader (
	input wire clk,
	input wire reset,
	input wire fetch_pkg::apb_req_t apb_req,
	output fetch_pkg::apb_rsp_t apb_rsp,
	// fetch status for reads
	input wire fetch_pkg::fetch_state_t state,
	input wire fetch_pkg::pc_t pc,
	output logic run,
	output fetch_pkg::imem_wr_t imem_wr
);

	// auto-incrementing load address
	fetch_pkg::pc_t load_addr;

	logic access;
	logic wr_access;
	logic rd_access;
	logic bad_addr;
	// data write refused while running
	logic busy_err;
	logic running;
	logic halted;
	fetch_pkg::word_t rd_val;

	////////////////////////////////////////////////////////////
	// apb phase decode
	////////////////////////////////////////////////////////////

	// zero wait states, access completes when penable is up
	assign access = apb_req.psel && apb_req.penable;
	assign wr_access = access && apb_req.pwrite;
	assign rd_access = access && !apb_req.pwrite;

	assign running = (state == fetch_pkg::st_run);
	assign halted = (state == fetch_pkg::st_halted);

	// register map and read mux
	always_comb begin
		rd_val = '0;
		bad_addr = 1'b0;
		case (apb_req.paddr)
			fetch_pkg::reg_ctrl:   rd_val = {31'd0, run};
			fetch_pkg::reg_addr:   rd_val = load_addr;
			// no memory read-back
			fetch_pkg::reg_data:   rd_val = '0;
			fetch_pkg::reg_status: rd_val = {30'd0, running, halted};
			fetch_pkg::reg_pc:     rd_val = pc;
			default:               bad_addr = 1'b1;
		endcase
	end

	assign busy_err = wr_access && (apb_req.paddr == fetch_pkg::reg_data) && run;

	always_comb begin
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access && (bad_addr || busy_err);
		// bus is quiet outside a read access
		apb_rsp.prdata = rd_access ? rd_val : '0;
	end

	////////////////////////////////////////////////////////////
	// memory write strobe
	////////////////////////////////////////////////////////////

	// write lands on the access edge
	always_comb begin
		imem_wr.en = wr_access && (apb_req.paddr == fetch_pkg::reg_data) && !run;
		imem_wr.addr = load_addr;
		imem_wr.data = apb_req.pwdata;
	end

	////////////////////////////////////////////////////////////
	// control registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
			load_addr <= '0;
		end else if (wr_access && !bad_addr) begin
			case (apb_req.paddr)
				fetch_pkg::reg_ctrl: run <= apb_req.pwdata[0];
				fetch_pkg::reg_addr: load_addr <= apb_req.pwdata;
				fetch_pkg::reg_data: begin
					// step only when the word was stored
					if (!run) begin
						load_addr <= load_addr + 32'd1;
					end
				end
				// status and pc are read only
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
	parameter int imem_depth = 256
) (
	input wire clk,
	// read address is the next pc
	input wire fetch_pkg::pc_t rd_addr,
	output fetch_pkg::word_t rd_data,
	// rd_data is the halt word
	output logic is_halt,
	input wire fetch_pkg::imem_wr_t wr
);

	// index width from depth
	localparam int addr_bits = $clog2(imem_depth);

	typedef logic [addr_bits-1:0] mem_addr_t;

	fetch_pkg::word_t mem [imem_depth];

	mem_addr_t rd_idx;
	mem_addr_t wr_idx;

	////////////////////////////////////////////////////////////
	// address truncation
	////////////////////////////////////////////////////////////

	// upper pc bits wrap
	assign rd_idx = rd_addr[addr_bits-1:0];
	assign wr_idx = wr.addr[addr_bits-1:0];

	////////////////////////////////////////////////////////////
	// ram
	////////////////////////////////////////////////////////////

	// load port, only used while fetch is stopped
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr_idx] <= wr.data;
		end
	end

	// registered read, output lines up with the pc register
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_idx];
	end

	// single comparator for the whole stage
	assign is_halt = (rd_data == fetch_pkg::halt_word);

endmodule

`default_nettype wire

// File: hdl/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
	input wire clk,
	input wire reset,
	// run bit from the debug port
	input wire logic run,
	input wire logic stall,
	input wire fetch_pkg::redirect_t redirect,
	// memory word at pc is the halt word
	input wire logic halt_seen,
	output fetch_pkg::pc_t pc,
	output fetch_pkg::pc_t pc_fetch,
	output fetch_pkg::fetch_state_t state
);

	fetch_pkg::pc_t pc_inc;
	fetch_pkg::pc_t pc_target;
	fetch_pkg::fetch_state_t state_next;

	////////////////////////////////////////////////////////////
	// incrementer and source select
	////////////////////////////////////////////////////////////

	// word addressed, so plus one
	assign pc_inc = pc + 32'd1;

	always_comb begin
		case (redirect.pc_src)
			fetch_pkg::pc_branch:   pc_target = redirect.branch_target;
			fetch_pkg::pc_jump:     pc_target = redirect.jump_target;
			fetch_pkg::pc_register: pc_target = redirect.reg_target;
			default:                pc_target = pc_inc;
		endcase
	end

	////////////////////////////////////////////////////////////
	// hold / redirect / advance
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		// default is hold
		pc_fetch = pc;
		if (!run) begin
			// stop from any state, pc back to zero
			state_next = fetch_pkg::st_idle;
			pc_fetch = '0;
		end else begin
			case (state)
				fetch_pkg::st_idle: begin
					// start at word 0
					state_next = fetch_pkg::st_run;
					pc_fetch = '0;
				end
				fetch_pkg::st_run: begin
					// stall wins over redirect
					if (!stall) begin
						if (redirect.pc_src == fetch_pkg::pc_seq && halt_seen) begin
							// halt word captured this edge, pc freezes
							state_next = fetch_pkg::st_halted;
						end else begin
							pc_fetch = pc_target;
						end
					end
				end
				// halted holds until run drops
				fetch_pkg::st_halted: state_next = fetch_pkg::st_halted;
				default: begin
					state_next = fetch_pkg::st_idle;
					pc_fetch = '0;
				end
			endcase
		end
	end

	// pc register takes the same value the memory reads at
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetch_pkg::st_idle;
			pc <= '0;
		end else begin
			state <= state_next;
			pc <= pc_fetch;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////
	// widths with a meaning
	////////////////////////////////////////////////////////////

	// one instruction word
	typedef logic [31:0] word_t;
	// word address, pc counts in words
	typedef logic [31:0] pc_t;
	// apb register offset
	typedef logic [7:0] apb_addr_t;

	// all ones word stops fetch
	localparam word_t halt_word = '1;

	// debug port register map, byte offsets
	localparam apb_addr_t reg_ctrl   = 8'h00;
	localparam apb_addr_t reg_addr   = 8'h04;
	localparam apb_addr_t reg_data   = 8'h08;
	localparam apb_addr_t reg_status = 8'h0C;
	localparam apb_addr_t reg_pc     = 8'h10;

	////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////

	// next pc source, from decode/control
	typedef enum logic [1:0] {
		pc_seq      = 2'd0,
		pc_branch   = 2'd1,
		pc_jump     = 2'd2,
		pc_register = 2'd3
	} pc_src_t;

	// fetch run/halt machine
	typedef enum logic [1:0] {
		st_idle    = 2'd0,
		st_run     = 2'd1,
		st_halted  = 2'd2
	} fetch_state_t;

	////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////

	// 98 bits
	typedef struct packed {
		pc_src_t pc_src;
		pc_t     branch_target;
		pc_t     jump_target;
		pc_t     reg_target;
	} redirect_t;

	// if/id register, 97 bits
	typedef struct packed {
		logic  valid;
		pc_t   pc;
		pc_t   pc_next;
		word_t instr;
	} if_id_t;

	// memory write port, 65 bits
	typedef struct packed {
		logic  en;
		pc_t   addr;
		word_t data;
	} imem_wr_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		word_t     pwdata;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire
